//--- compile.f
+incdir+verilog
verilog/pea_pkg.sv
verilog/token_fifo.sv
verilog/pea_alu.sv
verilog/firing_sequencer.sv
verilog/pea_top.sv
test/pea_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pea testbench under verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pea_tb \
    -f compile.f -Mdir obj_dir -o pea_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pea_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# the pass line stands alone in the log.
if grep -qx "No errors" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- test/pea_tb.sv
`timescale 1ns/10ps
`include "pea_defines.svh"

module pea_tb import pea_pkg::*; ();

    localparam int CLK_NS      = 4;
    localparam int N_TESTS     = 6;
    localparam int FIRE_CYCLES = `PEA_FIFO_DEPTH * (7 + 4) + 4;   // full drain, arg1 of 7.
    localparam int MARGIN      = 10;
    localparam int WATCHDOG_NS = N_TESTS * FIRE_CYCLES * CLK_NS * MARGIN;

    logic                   clk, rst, cmd_wr, data_wr, invoke;
    logic [`PEA_WORD-1:0]   cmd_wdata, data_wdata;
    logic [1:0]             next_instr;
    logic [`PEA_PTR_W:0]    cmd_pop, data_pop;
    logic                   fc, wr_out;
    logic [`PEA_RES_W-1:0]  result;
    pea_status_t            status;
    logic [`PEA_OP_W-1:0]   instr;
    logic [`PEA_ARG2_W-1:0] arg2;

    logic [`PEA_WORD-1:0]  model_cmd[$], model_data[$];   // mirrors of both fifos.
    logic [`PEA_RES_W-1:0] exp_result[$], got_result[$];
    pea_status_t           exp_status[$], got_status[$];
    integer seed = 32'h6a5f765e;
    int     errors = 0, tests_run = 0, tests_failed = 0, errs_at_start;
    string  cur_test;

    pea_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    // record every output beat mid-cycle.
    always @(negedge clk)
    begin
        if (wr_out)
        begin
            got_result.push_back(result);
            got_status.push_back(status);
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else
        begin
            $display("FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("ERROR %s: %s", cur_test, what);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
        rst = 1'b0;                                      // reset held 2 cycles.
        {cmd_wr, data_wr, invoke, next_instr, cmd_wdata, data_wdata} = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b1;
        model_cmd.delete();
        model_data.delete();
        got_result.delete();
        got_status.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errs_at_start)
            $display("test %s passed", cur_test);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, errors - errs_at_start);
        end
    endtask

    // writes start 1 ns after an edge and end 1 ns after the next.
    task automatic write_cmd(input logic [7:0] op, input logic [2:0] a1, input logic [4:0] a2);
        cmd_wr    = 1'b1;
        cmd_wdata = {op, a1, a2};
        if (model_cmd.size() < `PEA_FIFO_DEPTH)
            model_cmd.push_back({op, a1, a2});           // full fifo drops it.
        @(posedge clk);
        #1 cmd_wr = 1'b0;
    endtask

    task automatic load_data(input int n, input logic [15:0] mask);
        for (int i = 0; i < n; i++)
        begin
            data_wr    = 1'b1;
            data_wdata = 16'($random(seed)) & mask;
            if (model_data.size() < `PEA_FIFO_DEPTH)
                model_data.push_back(data_wdata);
            @(posedge clk);
            #1;
        end
        data_wr = 1'b0;
    endtask

    // expected beat for one command, folding the mirrored data tokens.
    task automatic model_command(input logic [15:0] word);
        logic [7:0]  op;
        logic [2:0]  a1;
        logic [4:0]  a2;
        logic [15:0] tok;
        logic [31:0] acc;
        logic        known;
        pea_status_t st;
        op    = word[15:8];
        a1    = word[7:5];
        a2    = word[4:0];
        known = (op == OP_SUM) || (op == OP_MAX) || (op == OP_SCALE) || (op == OP_COUNT);
        acc   = '0;
        st    = '0;
        st.opcode   = op;
        st.arg2     = a2;
        st.err_data = (model_data.size() < a1);
        st.err_op   = !known;
        if (!st.err_data && known)
        begin
            for (int i = 0; i < a1; i++)
            begin
                tok = model_data.pop_front();
                if (op == OP_MAX)
                    acc = (tok > acc) ? {16'h0, tok} : acc;
                else if (op == OP_COUNT)
                    acc = acc + ((tok > a2) ? 1 : 0);
                else
                    acc = acc + tok;
            end
            acc         = (op == OP_SCALE) ? acc << a2 : acc;
            st.consumed = a1;
        end
        exp_result.push_back(acc);
        exp_status.push_back(st);
    endtask

    // invoke, wait for fc, watch a while for a stray firing, then compare.
    task automatic fire(input logic [1:0] mode, input int reinvoke_at, output int fc_cnt);
        int cyc;
        exp_result.delete();
        exp_status.delete();
        got_result.delete();
        got_status.delete();
        if (mode == MODE_DRAIN)
        begin
            while (model_cmd.size() > 0)
                model_command(model_cmd.pop_front());
        end
        else if (model_cmd.size() > 0 && mode == MODE_SKIP)
            void'(model_cmd.pop_front());                // dropped unexecuted.
        else if (model_cmd.size() > 0)
            model_command(model_cmd.pop_front());        // code 3 acts as one.
        invoke     = 1'b1;
        next_instr = mode;
        @(posedge clk);
        #1 invoke = 1'b0;
        fc_cnt = 0;
        cyc    = 0;
        while (fc_cnt == 0 && cyc < FIRE_CYCLES)
        begin
            @(negedge clk);
            if (fc)
                fc_cnt++;
            @(posedge clk);
            #1 invoke = (cyc == reinvoke_at) && (fc_cnt == 0);
            if (invoke)
                next_instr = (mode == MODE_DRAIN) ? MODE_ONE : MODE_DRAIN;   // must be ignored.
            cyc++;
        end
        invoke = 1'b0;
        check_true(fc_cnt > 0, "no fire-complete before the cycle limit");
        repeat (8)
        begin
            @(negedge clk);
            if (fc)
                fc_cnt++;
        end
        @(posedge clk);
        #1;
        check_value("beat count", exp_result.size(), got_result.size());
        for (int i = 0; i < exp_result.size() && i < got_result.size(); i++)
        begin
            check_value($sformatf("beat %0d result", i), exp_result[i], got_result[i]);
            check_value($sformatf("beat %0d status", i), exp_status[i], got_status[i]);
        end
        check_value("cmd population", model_cmd.size(), cmd_pop);
        check_value("data population", model_data.size(), data_pop);
    endtask

    task automatic run_one(input logic [7:0] op, input logic [2:0] a1, input logic [4:0] a2,
                           input logic [15:0] mask, input logic [1:0] mode);
        int fcs;
        int pre;
        load_data(a1, mask);
        write_cmd(op, a1, a2);
        pre = data_pop;
        fire(mode, -1, fcs);
        check_value("fc pulses", 1, fcs);
        check_value("data pop drop", pre - a1, data_pop);
        check_value("instr", op, instr);
        check_value("arg2", a2, arg2);
    endtask

    task automatic test_idle();
        int fcs;
        begin_test("idle");
        repeat (4)
        begin
            @(negedge clk);
            check_true(!fc && !wr_out, "fc or wr_out high after reset");
        end
        check_value("cmd pop", 0, cmd_pop);
        check_value("data pop", 0, data_pop);
        @(posedge clk);
        #1 fire(MODE_ONE, -1, fcs);                      // empty fifos still complete.
        check_value("fc pulses", 1, fcs);
        end_test();
    endtask

    task automatic test_single();
        begin_test("single");
        run_one(OP_SUM, 3'd5, 5'd0, 16'hffff, MODE_ONE);
        run_one(OP_MAX, 3'd7, 5'd0, 16'hffff, MODE_ONE);
        run_one(OP_SCALE, 3'd3, 5'd4, 16'hffff, MODE_ONE);
        run_one(OP_COUNT, 3'd6, 5'd20, 16'h003f, 2'b11);
        end_test();
    endtask

    task automatic test_errors();
        int fcs;
        begin_test("errors");
        load_data(2, 16'hffff);
        write_cmd(OP_SUM, 3'd5, 5'd1);                   // data shortfall.
        write_cmd(8'h7e, 3'd1, 5'd2);                    // unknown opcode.
        fire(MODE_ONE, -1, fcs);
        check_value("err_data", 1, got_status.size() > 0 ? got_status[0].err_data : 1'b0);
        fire(MODE_ONE, -1, fcs);
        check_value("err_op", 1, got_status.size() > 0 ? got_status[0].err_op : 1'b0);
        check_value("data pop kept", 2, data_pop);
        end_test();
    endtask

    task automatic test_drain();
        int fcs;
        begin_test("drain");
        load_data(14, 16'h00ff);
        write_cmd(OP_SUM, 3'd4, 5'd0);
        write_cmd(OP_COUNT, 3'd3, 5'd30);
        write_cmd(OP_SCALE, 3'd2, 5'd9);
        write_cmd(OP_MAX, 3'd5, 5'd0);
        fire(MODE_DRAIN, -1, fcs);
        check_value("fc pulses", 1, fcs);
        check_true(cmd_pop == 0 && data_pop == 0, "fifos not empty after drain");
        end_test();
    endtask

    task automatic test_skip();
        int fcs;
        begin_test("skip");
        load_data(3, 16'hffff);
        write_cmd(OP_SUM, 3'd3, 5'd0);
        fire(MODE_SKIP, -1, fcs);
        check_value("fc pulses", 1, fcs);
        check_value("data pop kept", 3, data_pop);
        end_test();
    endtask

    task automatic test_fill();
        int fcs;
        begin_test("fill");
        load_data(`PEA_FIFO_DEPTH + 4, 16'hffff);        // last four are dropped.
        check_value("saturated pop", `PEA_FIFO_DEPTH, data_pop);
        write_cmd(OP_SUM, 3'd7, 5'd0);
        write_cmd(OP_MAX, 3'd7, 5'd0);
        write_cmd(OP_SUM, 3'd2, 5'd0);                   // the 15th and 16th tokens.
        fire(MODE_DRAIN, 3, fcs);                        // second invoke mid-firing.
        check_value("fc pulses", 1, fcs);
        end_test();
    endtask

    initial
    begin
        {cmd_wr, data_wr, invoke, next_instr, cmd_wdata, data_wdata} = '0;
        rst = 1'b0;
        test_idle();
        test_single();
        test_errors();
        test_drain();
        test_skip();
        test_fill();
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- verilog/firing_sequencer.sv
`timescale 1ns/10ps
`include "pea_defines.svh"

module firing_sequencer import pea_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  pea_mode_e              mode,
    input  logic [`PEA_WORD-1:0]   cmd_head,
    input  logic                   cmd_empty,
    input  logic [`PEA_WORD-1:0]   data_head,
    input  logic [`PEA_PTR_W:0]    data_pop,
    output logic                   cmd_rd,
    output logic                   data_rd,
    output logic                   wr_out,
    output logic [`PEA_RES_W-1:0]  result,
    output pea_status_t            status,
    output logic [`PEA_OP_W-1:0]   instr,
    output logic [`PEA_ARG2_W-1:0] arg2,
    output logic                   done
);

    seq_state_e              state_q;     // current state.
    seq_state_e              state_d;     // next state.
    pea_cmd_t                cmd_q;       // command being executed.
    logic [`PEA_ARG1_W-1:0]  pop_cnt;     // data tokens popped so far.
    logic                    err_data_q;  // shortfall seen at check.
    logic                    err_op_q;    // bad opcode seen at check.
    logic                    short_data;  // fewer tokens than arg1.
    logic                    op_valid;    // from the accumulator.
    logic                    bad_cmd;     // either error now.
    logic                    last_pop;    // this pop completes arg1.
    logic                    alu_clear;   // zero the accumulator.
    logic [`PEA_RES_W-1:0]   alu_result;  // folded value.

    assign short_data = data_pop < {{(`PEA_PTR_W+1-`PEA_ARG1_W){1'b0}}, cmd_q.arg1};
    assign bad_cmd    = short_data || !op_valid;
    assign last_pop   = ({1'b0, pop_cnt} + 1'b1) == {1'b0, cmd_q.arg1};

    // moore outputs, all low in S_IDLE.
    assign cmd_rd    = (state_q == S_READ_CMD);
    assign data_rd   = (state_q == S_POP_DATA);
    assign wr_out    = (state_q == S_EMIT);
    assign done      = (state_q == S_DONE);
    assign alu_clear = (state_q == S_CHK_DATA) && !bad_cmd;

    pea_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .clear    (alu_clear),
        .acc_en   (data_rd),
        .token    (data_head),
        .cmd      (cmd_q),
        .result   (alu_result),
        .op_valid (op_valid)
    );

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
                if (start)
                    state_d = S_CHK_CMD;
            S_CHK_CMD:
                state_d = cmd_empty ? S_DONE : S_READ_CMD;   // nothing queued ends it.
            S_READ_CMD:
                state_d = (mode == MODE_SKIP) ? S_DONE : S_CHK_DATA;
            S_CHK_DATA:
                if (bad_cmd || cmd_q.arg1 == '0)
                    state_d = S_EMIT;                        // no data to pop.
                else
                    state_d = S_POP_DATA;
            S_POP_DATA:
                if (last_pop)
                    state_d = S_EMIT;
            S_EMIT:
                state_d = (mode == MODE_DRAIN) ? S_CHK_CMD : S_DONE;
            S_DONE:
                state_d = S_IDLE;
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q    <= S_IDLE;
            cmd_q      <= '0;
            pop_cnt    <= '0;
            err_data_q <= 1'b0;
            err_op_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            case (state_q)
                S_READ_CMD:
                begin
                    cmd_q   <= pea_cmd_t'(cmd_head);   // latch head as it pops.
                    pop_cnt <= '0;
                end
                S_CHK_DATA:
                begin
                    err_data_q <= short_data;
                    err_op_q   <= !op_valid;
                    pop_cnt    <= '0;
                end
                S_POP_DATA:
                begin
                    pop_cnt <= pop_cnt + 1'b1;        // one token per cycle.
                end
                default:
                begin
                    pop_cnt <= pop_cnt;
                end
            endcase
        end
    end

    // on error the accumulator was never cleared, so mask it.
    assign result = (err_data_q || err_op_q) ? '0 : alu_result;

    always_comb
    begin
        status          = '0;
        status.opcode   = cmd_q.opcode;
        status.consumed = pop_cnt;                    // zero on the error path.
        status.arg2     = cmd_q.arg2;
        status.err_data = err_data_q;
        status.err_op   = err_op_q;
    end

    assign instr = cmd_q.opcode;
    assign arg2  = cmd_q.arg2;

    // a beat has popped exactly arg1 tokens, none on error.
    a_emit_count: assert property (@(posedge clk) disable iff (!rst)
        wr_out |-> pop_cnt == ((err_data_q || err_op_q) ? '0 : cmd_q.arg1))
        else $error("wr_out with a popped count that does not match arg1");
    a_pop_bounds: assert property (@(posedge clk) disable iff (!rst)
        data_rd |-> (data_pop != '0 && pop_cnt < cmd_q.arg1))
        else $error("data_rd past arg1 or with no data queued");

endmodule

//--- verilog/pea_alu.sv
`timescale 1ns/10ps
`include "pea_defines.svh"

module pea_alu import pea_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  acc_en,
    input  logic [`PEA_WORD-1:0]  token,
    input  pea_cmd_t              cmd,
    output logic [`PEA_RES_W-1:0] result,
    output logic                  op_valid
);

    pea_opcode_e            op;          // decoded opcode.
    logic [`PEA_RES_W-1:0]  acc;         // running fold.
    logic [`PEA_RES_W-1:0]  tok_ext;     // token widened to the result.
    logic [`PEA_WORD-1:0]   arg2_ext;    // operand widened to a token.

    assign op       = pea_opcode_e'(cmd.opcode);
    assign tok_ext  = {{(`PEA_RES_W-`PEA_WORD){1'b0}}, token};
    assign arg2_ext = {{(`PEA_WORD-`PEA_ARG2_W){1'b0}}, cmd.arg2};

    // opcodes outside the enum are flagged to the sequencer.
    always_comb
    begin
        case (op)
            OP_SUM, OP_MAX, OP_SCALE, OP_COUNT: op_valid = 1'b1;
            default:                            op_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            acc <= '0;
        end
        else if (clear)
        begin
            acc <= '0;                               // new command.
        end
        else if (acc_en)
        begin
            case (op)
                OP_SUM, OP_SCALE:
                begin
                    acc <= acc + tok_ext;            // shift applied on output.
                end
                OP_MAX:
                begin
                    if (tok_ext > acc)
                    begin
                        acc <= tok_ext;              // new maximum.
                    end
                end
                OP_COUNT:
                begin
                    if (token > arg2_ext)
                    begin
                        acc <= acc + 1'b1;           // one more above threshold.
                    end
                end
                default:
                begin
                    acc <= acc;                      // unknown op, hold.
                end
            endcase
        end
    end

    // scale only touches the read-out, the sum itself stays unshifted.
    assign result = (op == OP_SCALE) ? (acc << cmd.arg2) : acc;

endmodule

//--- verilog/pea_defines.svh
`ifndef PEA_DEFINES_SVH
`define PEA_DEFINES_SVH

// token and result widths.
`define PEA_WORD        16              // command and data token width.
`define PEA_RES_W       32              // result and status token width.

// input fifo geometry.
`define PEA_FIFO_DEPTH  16              // entries per input fifo.
`define PEA_PTR_W       4               // log2 of the depth.

// command token layout, msb first: opcode, arg1, arg2.
`define PEA_OP_W        8               // opcode in bits 15:8.
`define PEA_ARG1_W      3               // arg1 in bits 7:5, data token count.
`define PEA_ARG2_W      5               // arg2 in bits 4:0, operand.

// status token layout after the command echo and the two error flags.
`define PEA_PAD_W       14              // zero fill at the bottom.

`endif

//--- verilog/pea_pkg.sv
`include "pea_defines.svh"

package pea_pkg;

    // opcodes carried in the top byte of a command token.
    typedef enum logic [`PEA_OP_W-1:0] {
        OP_SUM   = 8'h01,               // plain sum.
        OP_MAX   = 8'h02,               // unsigned maximum.
        OP_SCALE = 8'h03,               // sum shifted left by arg2.
        OP_COUNT = 8'h04                // tokens above arg2.
    } pea_opcode_e;

    // firing mode, sampled at invoke; code 3 acts like MODE_ONE.
    typedef enum logic [1:0] {
        MODE_ONE   = 2'b00,             // one command.
        MODE_DRAIN = 2'b01,             // every queued command.
        MODE_SKIP  = 2'b10              // drop one command.
    } pea_mode_e;

    typedef enum logic [2:0] {
        S_IDLE, S_CHK_CMD, S_READ_CMD, S_CHK_DATA, S_POP_DATA, S_EMIT, S_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        T_IDLE, T_START, T_WAIT
    } top_state_e;

    // opcode kept as raw bits so an unknown code survives decoding.
    typedef struct packed {
        logic [`PEA_OP_W-1:0]   opcode;   // operation.
        logic [`PEA_ARG1_W-1:0] arg1;     // tokens to consume.
        logic [`PEA_ARG2_W-1:0] arg2;     // operand.
    } pea_cmd_t;

    typedef struct packed {
        logic [`PEA_OP_W-1:0]   opcode;   // echoed opcode.
        logic [`PEA_ARG1_W-1:0] consumed; // tokens actually popped.
        logic [`PEA_ARG2_W-1:0] arg2;     // echoed operand.
        logic                   err_data; // data fifo short of arg1.
        logic                   err_op;   // opcode not recognized.
        logic [`PEA_PAD_W-1:0]  pad;      // always zero.
    } pea_status_t;

endpackage

//--- verilog/pea_top.sv
`timescale 1ns/10ps
`include "pea_defines.svh"

module pea_top import pea_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_wr,
    input  logic [`PEA_WORD-1:0]   cmd_wdata,
    input  logic                   data_wr,
    input  logic [`PEA_WORD-1:0]   data_wdata,
    input  logic                   invoke,
    input  logic [1:0]             next_instr,
    output logic [`PEA_PTR_W:0]    cmd_pop,
    output logic [`PEA_PTR_W:0]    data_pop,
    output logic                   fc,
    output logic                   wr_out,
    output logic [`PEA_RES_W-1:0]  result,
    output pea_status_t            status,
    output logic [`PEA_OP_W-1:0]   instr,
    output logic [`PEA_ARG2_W-1:0] arg2
);

    top_state_e            state_q;     // invoke fsm state.
    pea_mode_e             mode_q;      // mode sampled at invoke.
    logic                  start;       // one-cycle kick to the sequencer.
    logic                  done;        // sequencer finished.
    logic                  cmd_rd;      // command pop.
    logic                  data_rd;     // data pop.
    logic                  cmd_empty;   // no command queued.
    logic [`PEA_WORD-1:0]  cmd_head;    // next command token.
    logic [`PEA_WORD-1:0]  data_head;   // next data token.

    token_fifo cmd_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr    (cmd_wr),
        .wdata (cmd_wdata),
        .rd    (cmd_rd),
        .rdata (cmd_head),
        .pop   (cmd_pop),
        .empty (cmd_empty),
        .full  ()
    );

    // the sequencer works from the data population, not the empty flag.
    token_fifo data_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr    (data_wr),
        .wdata (data_wdata),
        .rd    (data_rd),
        .rdata (data_head),
        .pop   (data_pop),
        .empty (),
        .full  ()
    );

    firing_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode_q),
        .cmd_head  (cmd_head),
        .cmd_empty (cmd_empty),
        .data_head (data_head),
        .data_pop  (data_pop),
        .cmd_rd    (cmd_rd),
        .data_rd   (data_rd),
        .wr_out    (wr_out),
        .result    (result),
        .status    (status),
        .instr     (instr),
        .arg2      (arg2),
        .done      (done)
    );

    // invoke is only heard in T_IDLE.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= T_IDLE;
            mode_q  <= MODE_ONE;
        end
        else
        begin
            case (state_q)
                T_IDLE:
                    if (invoke)
                    begin
                        state_q <= T_START;
                        mode_q  <= pea_mode_e'(next_instr);   // held for the firing.
                    end
                T_START:
                    state_q <= T_WAIT;                        // start lasts one cycle.
                T_WAIT:
                    if (done)
                        state_q <= T_IDLE;
                default:
                    state_q <= T_IDLE;
            endcase
        end
    end

    assign start = (state_q == T_START);
    assign fc    = done;                                      // fire-complete.

    a_fc_in_wait: assert property (@(posedge clk) disable iff (!rst) fc |-> state_q == T_WAIT)
        else $error("fire-complete outside T_WAIT");

endmodule

//--- verilog/token_fifo.sv
`timescale 1ns/10ps
`include "pea_defines.svh"

module token_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,
    input  logic [`PEA_WORD-1:0] wdata,
    input  logic                 rd,
    output logic [`PEA_WORD-1:0] rdata,
    output logic [`PEA_PTR_W:0]  pop,
    output logic                 empty,
    output logic                 full
);

    logic [`PEA_WORD-1:0]  mem [`PEA_FIFO_DEPTH];  // token storage.
    logic [`PEA_PTR_W-1:0] wr_ptr;                 // next free slot.
    logic [`PEA_PTR_W-1:0] rd_ptr;                 // current head.
    logic [`PEA_PTR_W:0]   cnt;                    // population.
    logic                  do_wr;                  // accepted write.
    logic                  do_rd;                  // accepted read.

    assign empty = (cnt == '0);                    // nothing stored.
    assign full  = (cnt == `PEA_FIFO_DEPTH);       // every slot taken.
    assign do_wr = wr && !full;                    // full drops the write.
    assign do_rd = rd && !empty;                   // guard the head.

    // show-ahead head word.
    assign rdata = mem[rd_ptr];
    assign pop   = cnt;

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wdata;                  // store at the tail.
        end
    end

    // depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;           // advance tail.
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;           // advance head.
            end
            case ({do_wr, do_rd})
                2'b10:   cnt <= cnt + 1'b1;        // write only.
                2'b01:   cnt <= cnt - 1'b1;        // read only.
                default: cnt <= cnt;               // both or neither.
            endcase
        end
    end

    // the sequencer checks populations first, so it never pops an empty fifo.
    a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst) rd |-> !empty)
        else $error("token_fifo read while empty");

endmodule
